// ==== src/modulation_defines.svh ====
`ifndef MODULATION_DEFINES_SVH
`define MODULATION_DEFINES_SVH

// --------------------
// Array geometry
// --------------------

// Transducers driven per frame.
`define NUM_TRANS 249

// Independent modulation waveforms held in memory.
`define NUM_SEGMENT 2

// Samples per segment are 2**MOD_IDX_W.
`define MOD_IDX_W 15

// --------------------
// Host bus
// --------------------

`define WB_ADR_W 17
`define WB_DAT_W 32

`endif

// ==== src/modulation_pkg.sv ====
`default_nettype none

`include "modulation_defines.svh"

package modulation_pkg;

  // --------------------
  // Drive stream payloads
  // --------------------

  typedef logic [7:0] intensity_t;
  typedef logic [7:0] phase_t;

  // --------------------
  // Modulation memory
  // --------------------

  typedef logic [7:0] mod_value_t;
  typedef logic [`MOD_IDX_W-1:0] mod_idx_t;

  // --------------------
  // Register window
  // --------------------

  // Word offsets used when address bit 16 is set.
  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0, // Bit 0 is the segment, bit 1 is stop.
    REG_CYCLE0 = 2'd1, // Last index of segment 0.
    REG_CYCLE1 = 2'd2  // Last index of segment 1.
  } mod_ctrl_reg_e;

endpackage

`default_nettype wire

// ==== src/delay_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fixed latency shift line. Any payload type can be carried.
module delay_fifo #(
  parameter int DEPTH = 3,
  parameter type T = logic [7:0]
) (
  input  logic CLK,
  input  T     din,
  output T     dout
);

  T stage [DEPTH];

  always_ff @(posedge CLK) begin
    stage[0] <= din;
    for (int i = 1; i < DEPTH; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  assign dout = stage[DEPTH-1]; // Oldest entry leaves after DEPTH edges.

endmodule

`default_nettype wire

// ==== src/mult_8x9.sv ====
`timescale 1ns/1ps
`default_nettype none

// Unsigned 8 by 9 multiply. Input and product registers map onto the
// A/B and P registers of a DSP slice.
module mult_8x9 (
  input  logic        CLK,
  input  logic [7:0]  a,
  input  logic [8:0]  b,
  output logic [16:0] p
);

  logic [7:0]  a_q;
  logic [8:0]  b_q;
  logic [16:0] p_q;

  // --------------------
  // Stage 1
  // --------------------
  always_ff @(posedge CLK) begin
    a_q <= a;
    b_q <= b;
  end

  // --------------------
  // Stage 2
  // --------------------
  always_ff @(posedge CLK) begin
    p_q <= a_q * b_q; // Full 17 bit product.
  end

  assign p = p_q;

endmodule

`default_nettype wire

// ==== src/modulation_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "modulation_defines.svh"

// Modulation sample store, one region per segment. The read side has a
// RAM register and an output register, so a new address is seen two
// cycles later.
module modulation_memory import modulation_pkg::*; (
  input  logic       CLK,
  input  logic       we,
  input  logic       wr_segment,
  input  mod_idx_t   wr_addr,
  input  mod_value_t wr_data,
  input  logic       rd_segment,
  input  mod_idx_t   rd_idx,
  output mod_value_t rd_value
);

  localparam int AddrW = $clog2(`NUM_SEGMENT) + `MOD_IDX_W;
  localparam int Words = `NUM_SEGMENT * (2 ** `MOD_IDX_W);

  mod_value_t mem [Words];
  mod_value_t ram_q;
  mod_value_t out_q;

  logic [AddrW-1:0] wr_word;
  logic [AddrW-1:0] rd_word;

  assign wr_word = {wr_segment, wr_addr}; // Segment is the top address bit.
  assign rd_word = {rd_segment, rd_idx};

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[wr_word] <= wr_data;
    end
  end

  // --------------------
  // Read port
  // --------------------
  always_ff @(posedge CLK) begin
    ram_q <= mem[rd_word];
    out_q <= ram_q;
  end

  assign rd_value = out_q;

  // Once the write enable has been driven to a known level it must stay known.
  a_we_known : assert property (@(posedge CLK) !$isunknown(we) |=> !$isunknown(we));

endmodule

`default_nettype wire

// ==== src/modulation_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "modulation_defines.svh"

// Host slave: address decode, control and cycle registers, and the
// per-segment frame index counters.
module modulation_ctrl import modulation_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [`WB_ADR_W-1:0] adr,
  input  logic [`WB_DAT_W-1:0] dat_w,
  output logic [`WB_DAT_W-1:0] dat_r,
  output logic                 ack,
  output logic                 mem_we,
  output logic                 mem_segment,
  output mod_idx_t             mem_addr,
  output mod_value_t           mem_data,
  input  logic                 din_valid,
  output mod_idx_t             mod_idx [`NUM_SEGMENT],
  output logic                 segment,
  output logic                 stop
);

  logic                    accept;
  logic                    reg_sel;
  logic                    reg_hit;
  logic                    reg_wr;
  mod_ctrl_reg_e           reg_off;
  logic [`NUM_SEGMENT-1:0] cycle_wr;
  logic [`WB_DAT_W-1:0]    rd_word;

  logic [1:0] ctrl_q;
  mod_idx_t   cycle_q [`NUM_SEGMENT];
  mod_idx_t   cnt_q   [`NUM_SEGMENT];

  // --------------------
  // Decode
  // --------------------
  assign accept  = cyc & stb & ~ack; // The ack cycle never starts a new transfer.
  assign reg_sel = adr[`WB_ADR_W-1];
  assign reg_hit = reg_sel & (adr[`WB_ADR_W-2:2] == '0);
  assign reg_off = mod_ctrl_reg_e'(adr[1:0]);
  assign reg_wr  = accept & we & reg_hit;

  always_comb begin
    for (int i = 0; i < `NUM_SEGMENT; i++) begin
      cycle_wr[i] = reg_wr && (int'(reg_off) == int'(REG_CYCLE0) + i);
    end
  end

  // Memory window writes go straight through in the accept cycle.
  assign mem_we      = accept & we & ~reg_sel;
  assign mem_segment = adr[`MOD_IDX_W];
  assign mem_addr    = adr[`MOD_IDX_W-1:0];
  assign mem_data    = dat_w[7:0];

  // --------------------
  // Registers and counters
  // --------------------
  always_ff @(posedge CLK) begin
    if (rst) begin
      ack    <= 1'b0;
      ctrl_q <= '0;
      for (int i = 0; i < `NUM_SEGMENT; i++) begin
        cycle_q[i] <= '0;
        cnt_q[i]   <= '0;
      end
    end else begin
      ack <= accept;
      if (reg_wr && reg_off == REG_CTRL) begin
        ctrl_q <= dat_w[1:0];
      end
      for (int i = 0; i < `NUM_SEGMENT; i++) begin
        if (cycle_wr[i]) begin
          cycle_q[i] <= dat_w[`MOD_IDX_W-1:0];
          cnt_q[i]   <= '0; // A new cycle length restarts the waveform.
        end else if (din_valid) begin
          cnt_q[i] <= (cnt_q[i] == cycle_q[i]) ? '0 : cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Memory reads are not supported and return zero.
  always_comb begin
    rd_word = '0;
    if (reg_hit) begin
      case (reg_off)
        REG_CTRL:   rd_word[1:0] = ctrl_q;
        REG_CYCLE0: rd_word[`MOD_IDX_W-1:0] = cycle_q[0];
        REG_CYCLE1: rd_word[`MOD_IDX_W-1:0] = cycle_q[1];
        default:    rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      dat_r <= rd_word;
    end
  end

  assign mod_idx = cnt_q;
  assign segment = ctrl_q[0];
  assign stop    = ctrl_q[1];

  // The host holds its request until it has seen ack.
  a_ack_within_request : assert property (
    @(posedge CLK) disable iff (rst) ack |-> cyc && stb
  );

endmodule

`default_nettype wire

// ==== src/modulation_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "modulation_defines.svh"

// Frame sequencer. Fetches one modulation sample per frame and scales the
// intensity burst by it, keeping the phase aligned.
module modulation_multiplier import modulation_pkg::*; #(
  parameter int DEPTH = `NUM_TRANS
) (
  input  logic       CLK,
  input  logic       rst,
  input  logic       din_valid,
  input  intensity_t intensity_in,
  input  phase_t     phase_in,
  input  mod_idx_t   mod_idx [`NUM_SEGMENT],
  input  logic       segment,
  input  logic       stop,
  output mod_idx_t   rd_idx,
  output logic       rd_segment,
  input  mod_value_t rd_value,
  output intensity_t intensity_out,
  output phase_t     phase_out,
  output logic       dout_valid
);

  localparam int CntW = $clog2(DEPTH);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_MOD_LOAD_0,
    WAIT_MOD_LOAD_1,
    WAIT_MUL_0,
    WAIT_MUL_1,
    RUN
  } state_t;

  state_t          state;
  logic [CntW-1:0] cnt_q;
  mod_idx_t        idx_q;
  logic            seg_q;
  logic            valid_q;

  intensity_t  intensity_dly;
  logic [8:0]  mod_plus1;
  logic [16:0] p;

  // --------------------
  // Datapath
  // --------------------
  delay_fifo #(
    .DEPTH(3),
    .T    (intensity_t)
  ) delay_fifo_intensity (
    .CLK (CLK),
    .din (intensity_in),
    .dout(intensity_dly)
  );

  // Phase skips the multiplier, so it needs two extra stages.
  delay_fifo #(
    .DEPTH(5),
    .T    (phase_t)
  ) delay_fifo_phase (
    .CLK (CLK),
    .din (phase_in),
    .dout(phase_out)
  );

  assign mod_plus1 = {1'b0, rd_value} + 9'd1; // 255 gives a gain of exactly one.

  mult_8x9 mult (
    .CLK(CLK),
    .a  (intensity_dly),
    .b  (mod_plus1),
    .p  (p)
  );

  assign intensity_out = p[15:8];

  // --------------------
  // Sequencer
  // --------------------
  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= IDLE;
      cnt_q   <= '0;
      idx_q   <= '0;
      seg_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          valid_q <= 1'b0;
          if (din_valid) begin
            if (!stop) begin // While stopped the old sample is read again.
              idx_q <= mod_idx[segment];
              seg_q <= segment;
            end
            state <= WAIT_MOD_LOAD_0;
          end
        end
        WAIT_MOD_LOAD_0: state <= WAIT_MOD_LOAD_1;
        WAIT_MOD_LOAD_1: state <= WAIT_MUL_0;
        WAIT_MUL_0:      state <= WAIT_MUL_1;
        WAIT_MUL_1: begin
          cnt_q <= '0;
          state <= RUN;
        end
        RUN: begin
          valid_q <= 1'b1;
          cnt_q   <= cnt_q + 1'b1;
          if (cnt_q == CntW'(DEPTH - 1)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign rd_idx     = idx_q;
  assign rd_segment = seg_q;
  assign dout_valid = valid_q;

  // The sender must leave enough gap for the previous burst to drain.
  a_frame_gap : assert property (
    @(posedge CLK) disable iff (rst) din_valid |-> state == IDLE && !valid_q
  );

endmodule

`default_nettype wire

// ==== src/modulation_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "modulation_defines.svh"

module modulation_top import modulation_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [`WB_ADR_W-1:0] adr,
  input  logic [`WB_DAT_W-1:0] dat_w,
  output logic [`WB_DAT_W-1:0] dat_r,
  output logic                 ack,
  input  logic                 din_valid,
  input  intensity_t           intensity_in,
  input  phase_t               phase_in,
  output intensity_t           intensity_out,
  output phase_t               phase_out,
  output logic                 dout_valid
);

  logic       mem_we;
  logic       mem_segment;
  mod_idx_t   mem_addr;
  mod_value_t mem_data;
  mod_idx_t   mod_idx [`NUM_SEGMENT];
  logic       segment;
  logic       stop;
  mod_idx_t   rd_idx;
  logic       rd_segment;
  mod_value_t rd_value;

  modulation_ctrl modulation_ctrl_inst (
    .CLK        (CLK),
    .rst        (rst),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .mem_we     (mem_we),
    .mem_segment(mem_segment),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .din_valid  (din_valid),
    .mod_idx    (mod_idx),
    .segment    (segment),
    .stop       (stop)
  );

  modulation_memory modulation_memory_inst (
    .CLK       (CLK),
    .we        (mem_we),
    .wr_segment(mem_segment),
    .wr_addr   (mem_addr),
    .wr_data   (mem_data),
    .rd_segment(rd_segment),
    .rd_idx    (rd_idx),
    .rd_value  (rd_value)
  );

  modulation_multiplier #(
    .DEPTH(`NUM_TRANS)
  ) modulation_multiplier_inst (
    .CLK          (CLK),
    .rst          (rst),
    .din_valid    (din_valid),
    .intensity_in (intensity_in),
    .phase_in     (phase_in),
    .mod_idx      (mod_idx),
    .segment      (segment),
    .stop         (stop),
    .rd_idx       (rd_idx),
    .rd_segment   (rd_segment),
    .rd_value     (rd_value),
    .intensity_out(intensity_out),
    .phase_out    (phase_out),
    .dout_valid   (dout_valid)
  );

endmodule

`default_nettype wire

// ==== tb/tb_modulation_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "modulation_defines.svh"

module tb_modulation_top import modulation_pkg::*;;

  localparam int AckTimeout   = 20;
  localparam int DrainTimeout = 2 * `NUM_TRANS + 20;
  localparam int FrameGap     = 12;
  localparam int RunLimit     = 60000;
  localparam int NumWords     = 2 ** `MOD_IDX_W;

  logic                 CLK;
  logic                 rst;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [`WB_ADR_W-1:0] adr;
  logic [`WB_DAT_W-1:0] dat_w;
  logic [`WB_DAT_W-1:0] dat_r;
  logic                 ack;
  logic                 din_valid;
  intensity_t           intensity_in;
  phase_t               phase_in;
  intensity_t           intensity_out;
  phase_t               phase_out;
  logic                 dout_valid;

  int    cycle_count;
  string test_name;

  // Host side model of the subsystem state.
  mod_value_t mem_m [`NUM_SEGMENT][NumWords];
  int         cycle_m [`NUM_SEGMENT];
  int         cnt_m [`NUM_SEGMENT];
  int         seg_m;
  int         stop_m;
  int         used_idx;
  int         used_seg;

  // Expected outputs in order, with the clock edge each one must be seen at.
  int exp_edge [$];
  int exp_int [$];
  int exp_ph [$];

  modulation_top modulation_top_inst (
    .CLK          (CLK),
    .rst          (rst),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .dat_r        (dat_r),
    .ack          (ack),
    .din_valid    (din_valid),
    .intensity_in (intensity_in),
    .phase_in     (phase_in),
    .intensity_out(intensity_out),
    .phase_out    (phase_out),
    .dout_valid   (dout_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------
  // Reporting
  // --------------------
  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("error %s: expected %0d, actual %0d", name, expected, actual);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic abort(input string what);
    $display("%s during %s", what, test_name);
    $display("sim failed");
    $fatal(1);
  endtask

  // Output intensity is the input times (sample + 1), upper byte kept.
  function automatic int scaled_intensity(input int intensity, input int sample);
    return (intensity * (sample + 1)) / 256;
  endfunction

  // --------------------
  // Bus access
  // --------------------
  function automatic logic [`WB_ADR_W-1:0] reg_addr(input int offset);
    logic [`WB_ADR_W-1:0] a;
    a = '0;
    a[`WB_ADR_W-1] = 1'b1;
    a[1:0] = offset[1:0];
    return a;
  endfunction

  function automatic logic [`WB_ADR_W-1:0] mem_addr(input int seg, input int idx);
    logic [`WB_ADR_W-1:0] a;
    a = '0;
    a[`MOD_IDX_W] = seg[0];
    a[`MOD_IDX_W-1:0] = idx[`MOD_IDX_W-1:0];
    return a;
  endfunction

  task automatic bus_access(input logic write, input logic [`WB_ADR_W-1:0] addr,
                            input logic [`WB_DAT_W-1:0] data,
                            output logic [`WB_DAT_W-1:0] rdata);
    int waited;
    @(posedge CLK);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= addr;
    dat_w <= data;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
      if (waited > AckTimeout) abort("no ack on a bus transfer");
    end while (!ack);
    rdata = dat_r;
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(posedge CLK);
    assert (!ack) else abort("ack stayed high for more than one cycle");
  endtask

  task automatic write_reg(input int offset, input int value);
    logic [`WB_DAT_W-1:0] unused;
    bus_access(1'b1, reg_addr(offset), value, unused);
    if (offset == int'(REG_CTRL)) begin
      seg_m  = value & 1;
      stop_m = (value >> 1) & 1;
    end else begin
      cycle_m[offset - int'(REG_CYCLE0)] = value & (NumWords - 1);
      cnt_m[offset - int'(REG_CYCLE0)]   = 0; // Counter restarts on a new length.
    end
  endtask

  task automatic check_read(input string name, input logic [`WB_ADR_W-1:0] addr,
                            input int expected);
    logic [`WB_DAT_W-1:0] rdata;
    bus_access(1'b0, addr, '0, rdata);
    assert (rdata == expected) else report_mismatch(name, expected, rdata);
  endtask

  task automatic write_sample(input int seg, input int idx, input int value);
    logic [`WB_DAT_W-1:0] unused;
    bus_access(1'b1, mem_addr(seg, idx), value, unused);
    mem_m[seg][idx] = value[7:0];
  endtask

  // Distinct values per segment so a wrong index always shows up.
  task automatic load_segment(input int seg, input int count);
    int base;
    base = $urandom % 256;
    for (int i = 0; i < count; i++) begin
      write_sample(seg, i, (base + i * 29 + seg * 101) % 256);
    end
  endtask

  // --------------------
  // Frames
  // --------------------
  task automatic send_frame();
    int         drive_edge;
    int         sample;
    intensity_t i_val;
    phase_t     p_val;
    if (!stop_m) begin
      used_idx = cnt_m[seg_m];
      used_seg = seg_m;
    end
    sample = mem_m[used_seg][used_idx];
    for (int s = 0; s < `NUM_SEGMENT; s++) begin
      cnt_m[s] = (cnt_m[s] == cycle_m[s]) ? 0 : cnt_m[s] + 1;
    end
    @(posedge CLK);
    drive_edge = cycle_count;
    din_valid <= 1'b1;
    for (int k = 0; k < `NUM_TRANS; k++) begin
      @(posedge CLK);
      din_valid <= 1'b0;
      i_val = $urandom;
      p_val = $urandom;
      if (k == 0) i_val = 8'd255; // Full scale and zero are always in the burst.
      if (k == 1) i_val = 8'd0;
      intensity_in <= i_val;
      phase_in     <= p_val;
      exp_edge.push_back(drive_edge + 7 + k);
      exp_int.push_back(scaled_intensity(i_val, sample));
      exp_ph.push_back(p_val);
    end
    @(posedge CLK);
    intensity_in <= '0;
    phase_in     <= '0;
    repeat (FrameGap) @(posedge CLK);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_edge.size() != 0) begin
      @(posedge CLK);
      waited++;
      if (waited > DrainTimeout) abort("frame outputs did not arrive");
    end
  endtask

  // --------------------
  // Comparing process
  // --------------------
  always @(posedge CLK) begin
    if (!rst) begin
      if (exp_edge.size() != 0) begin
        assert (cycle_count <= exp_edge[0])
          else abort("an expected output never appeared");
      end
      if (dout_valid) begin
        assert (exp_edge.size() != 0)
          else abort("dout_valid was high with no frame outstanding");
        if (exp_edge.size() != 0) begin
          assert (cycle_count == exp_edge[0])
            else report_mismatch({test_name, " timing"}, exp_edge[0], cycle_count);
          assert (intensity_out == exp_int[0])
            else report_mismatch({test_name, " intensity"}, exp_int[0], intensity_out);
          assert (phase_out == exp_ph[0])
            else report_mismatch({test_name, " phase"}, exp_ph[0], phase_out);
          void'(exp_edge.pop_front());
          void'(exp_int.pop_front());
          void'(exp_ph.pop_front());
        end
      end
    end
  end

  initial begin
    repeat (RunLimit) @(posedge CLK);
    abort("the run went past its cycle limit");
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    void'($urandom(49));
    cycle_count  = 0;
    test_name    = "reset";
    rst          = 1'b1;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    din_valid    = 1'b0;
    intensity_in = '0;
    phase_in     = '0;
    for (int s = 0; s < `NUM_SEGMENT; s++) begin
      cycle_m[s] = 0;
      cnt_m[s]   = 0;
    end
    seg_m    = 0;
    stop_m   = 0;
    used_idx = 0;
    used_seg = 0;
    repeat (2) @(posedge CLK);
    rst <= 1'b0;

    test_name = "single_frame";
    load_segment(0, 16);
    load_segment(1, 16);
    send_frame();
    drain();

    test_name = "index_wrap";
    write_reg(REG_CYCLE0, 3);
    for (int f = 0; f < 8; f++) begin
      send_frame();
    end
    drain();

    test_name = "segment_select";
    write_reg(REG_CYCLE0, 2);
    write_reg(REG_CYCLE1, 4);
    for (int f = 0; f < 6; f++) begin
      write_reg(REG_CTRL, (f == 1 || f == 2 || f == 4) ? 1 : 0);
      send_frame();
    end
    drain();

    test_name = "stop";
    write_reg(REG_CTRL, 0);
    write_reg(REG_CYCLE0, 5);
    send_frame();
    write_reg(REG_CTRL, 2);
    repeat (3) send_frame();
    write_reg(REG_CTRL, 0);
    repeat (2) send_frame();
    drain();

    test_name = "wishbone";
    write_reg(REG_CTRL, 1);
    check_read("read_ctrl", reg_addr(REG_CTRL), 1);
    write_reg(REG_CYCLE0, 1);
    check_read("read_cycle0", reg_addr(REG_CYCLE0), 1);
    check_read("read_cycle1", reg_addr(REG_CYCLE1), cycle_m[1]);
    check_read("read_memory", mem_addr(0, 0), 0);
    write_reg(REG_CTRL, 0);
    write_sample(0, 0, 255);
    write_sample(0, 1, 0);
    send_frame();
    send_frame();
    drain();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/modulation_pkg.sv
src/delay_fifo.sv
src/mult_8x9.sv
src/modulation_memory.sv
src/modulation_ctrl.sv
src/modulation_multiplier.sv
src/modulation_top.sv
tb/tb_modulation_top.sv

// ==== Bender.yml ====
package:
  name: modulation

sources:
  - include_dirs:
      - src
    files:
      - src/modulation_pkg.sv
      - src/delay_fifo.sv
      - src/mult_8x9.sv
      - src/modulation_memory.sv
      - src/modulation_ctrl.sv
      - src/modulation_multiplier.sv
      - src/modulation_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_modulation_top.sv
